/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;  // data word width.

    // major opcodes of the kept instruction set.
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // register-register arithmetic.
        opc_op_imm = 7'b0010011,  // register-immediate arithmetic.
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    // funct3 codes for arithmetic.
    localparam logic [2:0] f3_add_sub = 3'b000;  // bit 30 selects sub.
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;  // bit 30 selects sra.
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 codes for branches and memory access.
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;  // lw and sw.

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        src_a_reg  = 2'd0,  // register data 1.
        src_a_pc   = 2'd1,  // auipc.
        src_a_zero = 2'd2   // lui.
    } src_a_e;

    typedef struct packed {
        alu_op_e         alu_op;
        src_a_e          src_a;
        logic            src_b_imm;   // second operand is the immediate.
        logic            reg_write;
        logic            mem_write;
        logic            mem_to_reg;  // write back the loaded word.
        logic            branch;
        logic            branch_ne;   // taken when operands differ.
        logic [xlen-1:0] imm;
    } ctrl_t;

endpackage

/* logic/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder
    import rv_pkg::*;
(
    input  logic [xlen-1:0] instr,
    output ctrl_t           ctrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            bit30;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;

    // arithmetic operation from funct3 and the alternate bit.
    function automatic alu_op_e to_alu_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;  // f3_and.
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    // immediate formats, all sign extended from bit 31.
    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(xlen-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        ctrl        = '0;  // unknown opcodes leave everything inactive.
        ctrl.alu_op = alu_add;
        ctrl.src_a  = src_a_reg;

        case (opcode)
            opc_op: begin
                ctrl.alu_op    = to_alu_op(funct3, bit30);
                ctrl.reg_write = 1'b1;
            end

            opc_op_imm: begin
                // bit 30 belongs to the immediate of addi and only selects srai.
                ctrl.alu_op    = to_alu_op(funct3, bit30 && (funct3 == f3_srl_sra));
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.imm       = imm_i;
            end

            opc_load: begin
                if (funct3 == f3_word) begin  // only lw is kept.
                    ctrl.src_b_imm  = 1'b1;
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.imm        = imm_i;
                end
            end

            opc_store: begin
                if (funct3 == f3_word) begin  // only sw is kept.
                    ctrl.src_b_imm = 1'b1;
                    ctrl.mem_write = 1'b1;
                    ctrl.imm       = imm_s;
                end
            end

            opc_branch: begin
                if (funct3 == f3_beq || funct3 == f3_bne) begin
                    ctrl.alu_op    = alu_sub;  // zero flag means equal.
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = (funct3 == f3_bne);
                    ctrl.imm       = imm_b;
                end
            end

            opc_lui: begin
                ctrl.src_a     = src_a_zero;  // 0 + imm.
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.imm       = imm_u;
            end

            opc_auipc: begin
                ctrl.src_a     = src_a_pc;  // pc + imm.
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.imm       = imm_u;
            end

            default: begin
                ctrl = '0;  // no-op.
            end
        endcase
    end

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic            CLK,
    input  logic            RESET_N,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            write_en,
    input  logic [xlen-1:0] write_data,
    output logic [xlen-1:0] data1,
    output logic [xlen-1:0] data2
);

    logic [xlen-1:0] regs [32];

    // register 0 is never written, so it reads back as zero.
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd != 5'd0)) begin
            regs[rd] <= write_data;  // visible to reads next cycle.
        end
    end

    assign data1 = regs[rs1];  // combinational read ports.
    assign data2 = regs[rs2];

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu
    import rv_pkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    localparam int shamt_width = $clog2(xlen);

    logic [shamt_width-1:0] shamt;
    logic                   lt_signed;
    logic                   lt_unsigned;

    assign shamt       = b[shamt_width-1:0];  // low five bits of b.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);  // sign fill.
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            default:  result = '0;
        endcase
    end

    // used by beq and bne after a subtraction.
    assign zero = (result == '0);

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
#(
    parameter int addr_width = 10  // byte address width of both memories.
) (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic [xlen-1:0]       q_rom,
    output logic [addr_width-1:0] addr_rom,
    output logic [addr_width-1:0] addr_ram,
    input  logic [xlen-1:0]       q_ram,
    output logic [xlen-1:0]       q_w,
    output logic                  enable_w
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] next_pc;
    logic            branch_taken;

    ctrl_t           ctrl;

    logic [xlen-1:0] data1;
    logic [xlen-1:0] data2;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_result;
    logic            alu_zero;
    logic [xlen-1:0] write_back;

    rv_decoder i_rv_decoder (
        .instr (q_rom),
        .ctrl  (ctrl)
    );

    rv_regfile i_rv_regfile (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .rs1        (q_rom[19:15]),
        .rs2        (q_rom[24:20]),
        .rd         (q_rom[11:7]),
        .write_en   (ctrl.reg_write),
        .write_data (write_back),
        .data1      (data1),
        .data2      (data2)
    );

    // first operand is rs1, the pc for auipc or zero for lui.
    always_comb begin
        case (ctrl.src_a)
            src_a_pc:   operand_a = pc;
            src_a_zero: operand_a = '0;
            default:    operand_a = data1;
        endcase
    end

    assign operand_b = ctrl.src_b_imm ? ctrl.imm : data2;

    rv_alu i_rv_alu (
        .a      (operand_a),
        .b      (operand_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign write_back = ctrl.mem_to_reg ? q_ram : alu_result;  // load or alu.

    // beq takes on zero, bne on nonzero.
    assign branch_taken = ctrl.branch & (alu_zero ^ ctrl.branch_ne);

    assign pc_plus4  = pc + xlen'(4);
    assign pc_target = pc + ctrl.imm;
    assign next_pc   = branch_taken ? pc_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;  // first fetch at address 0.
        end else begin
            pc <= next_pc;
        end
    end

    assign addr_rom = pc[addr_width-1:0];
    assign addr_ram = alu_result[addr_width-1:0];  // truncated byte address.
    assign q_w      = data2;                        // store data is rs2.
    assign enable_w = ctrl.mem_write & RESET_N;     // no stores while in reset.

endmodule

/* test/rv_core_assertions.sv */
`timescale 1ns/1ps

module rv_core_assertions #(
    parameter int addr_width = 10
) (
    input logic                  CLK,
    input logic                  RESET_N,
    input logic [addr_width-1:0] addr_rom,
    input logic                  enable_w
);

    int failures = 0;  // failed assertions so far.

    // stores are held off for the whole reset.
    a_no_store_in_reset: assert property (@(posedge CLK) !RESET_N |-> !enable_w)
        else begin
            failures++;
            $error("enable_w high while RESET_N is low");
        end

    a_pc_aligned: assert property (@(posedge CLK) disable iff (!RESET_N)
                                   addr_rom[1:0] == 2'b00)
        else begin
            failures++;
            $error("addr_rom is not word aligned");
        end

    a_pc_known: assert property (@(posedge CLK) disable iff (!RESET_N) !$isunknown(addr_rom))
        else begin
            failures++;
            $error("addr_rom holds an unknown value");
        end

endmodule

bind rv_core rv_core_assertions #(.addr_width(addr_width)) i_rv_core_assertions (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .addr_rom (addr_rom),
    .enable_w (enable_w)
);

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb
    import rv_pkg::*;
();

    localparam int addr_width   = 10;
    localparam int depth        = 2 ** (addr_width - 2);  // words per memory.
    localparam int reset_cycles = 3;
    localparam int test_cycles  = 64;
    localparam int rand_cycles  = 220;
    localparam int total_cycles = 5 * (test_cycles + reset_cycles + 2)
                                  + rand_cycles + reset_cycles + 2;

    typedef struct packed {
        logic [addr_width-1:0] addr_rom;
        logic                  enable_w;
        logic [addr_width-1:0] addr_ram;
        logic [xlen-1:0]       q_w;
    } expected_t;

    logic                  CLK;
    logic                  RESET_N;
    logic [xlen-1:0]       q_rom;
    logic [addr_width-1:0] addr_rom;
    logic [addr_width-1:0] addr_ram;
    logic [xlen-1:0]       q_ram;
    logic [xlen-1:0]       q_w;
    logic                  enable_w;

    logic [xlen-1:0] rom [depth];
    logic [xlen-1:0] ram [depth];
    logic [xlen-1:0] s_pc;           // shadow architectural state.
    logic [xlen-1:0] s_regs [32];
    logic [xlen-1:0] s_ram [depth];
    logic            checking;
    int              wp;             // next free rom word.
    int              error_count;
    int              pass_count;
    int              fail_count;
    expected_t       exp_out;

    rv_core #(.addr_width(addr_width)) i_rv_core (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .q_rom    (q_rom),
        .addr_rom (addr_rom),
        .addr_ram (addr_ram),
        .q_ram    (q_ram),
        .q_w      (q_w),
        .enable_w (enable_w)
    );

    assign q_rom = rom[addr_rom[addr_width-1:2]];  // memories answer combinationally.
    assign q_ram = ram[addr_ram[addr_width-1:2]];

    always @(posedge CLK) begin
        if (enable_w) begin
            ram[addr_ram[addr_width-1:2]] <= q_w;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    function automatic logic [xlen-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic [xlen-1:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 1 : 0;
            3'd3: r = (a < b) ? 1 : 0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // executes one instruction on the shadow state and returns the port values.
    function automatic expected_t step_reference();
        logic [xlen-1:0] w, a, b, res, addr, next, imm_i, imm_s, imm_b, imm_u;
        logic [2:0]      f3;
        logic            wr;
        expected_t       e;
        w     = rom[s_pc[addr_width-1:2]];
        f3    = w[14:12];
        a     = s_regs[w[19:15]];
        b     = s_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'b0};
        e          = '0;
        e.addr_rom = s_pc[addr_width-1:0];
        e.q_w      = b;
        wr         = 1'b0;
        res        = '0;
        next       = s_pc + 4;
        case (w[6:0])
            opc_op: begin
                res = ref_alu(f3, w[30], a, b);
                wr  = 1'b1;
            end
            opc_op_imm: begin
                res = ref_alu(f3, w[30] && (f3 == 3'd5), a, imm_i);
                wr  = 1'b1;
            end
            opc_load: begin
                if (f3 == 3'd2) begin
                    addr = a + imm_i;
                    res  = s_ram[addr[addr_width-1:2]];
                    wr   = 1'b1;
                end
            end
            opc_store: begin
                if (f3 == 3'd2) begin
                    addr       = a + imm_s;
                    e.enable_w = 1'b1;
                    e.addr_ram = addr[addr_width-1:0];
                    s_ram[addr[addr_width-1:2]] = b;
                end
            end
            opc_branch: begin
                if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                    next = s_pc + imm_b;
                end
            end
            opc_lui: begin
                res = imm_u;
                wr  = 1'b1;
            end
            opc_auipc: begin
                res = s_pc + imm_u;
                wr  = 1'b1;
            end
            default: ;  // unknown opcode, nothing changes.
        endcase
        if (wr && w[11:7] != 5'd0) begin
            s_regs[w[11:7]] = res;
        end
        s_pc = next;
        return e;
    endfunction

    // compare mid cycle, once the combinational paths have settled.
    always @(negedge CLK) begin
        #1;
        if (checking) begin
            exp_out = step_reference();
            check_value("addr_rom", exp_out.addr_rom, addr_rom);
            check_value("enable_w", exp_out.enable_w, enable_w);
            if (exp_out.enable_w) begin
                check_value("addr_ram", exp_out.addr_ram, addr_ram);
                check_value("q_w", exp_out.q_w, q_w);
            end
        end
    end

    function automatic logic [31:0] enc_r(input logic alt, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    task automatic clear_rom();
        for (int i = 0; i < depth; i++) begin
            rom[i] = '0;  // zero words decode as no-ops.
        end
        wp = 0;
    endtask

    task automatic fill_ram();
        for (int i = 0; i < depth; i++) begin
            ram[i]   = (i + 1) * 32'h9e3779b9 ^ {i[7:0], 24'h5a3c0f};
            s_ram[i] = ram[i];
        end
    endtask

    task automatic emit(input logic [31:0] w);
        rom[wp] = w;
        wp++;
    endtask

    task automatic store_slot(input logic [4:0] rs2, input int slot);
        emit(enc_s(rs2, 5'd0, 12'h200 + 12'(4 * slot)));
    endtask

    task automatic run_test(input string name, input int cycles);
        int errors_before;
        errors_before = error_count;
        RESET_N = 1'b0;
        fill_ram();
        for (int i = 0; i < 32; i++) begin
            s_regs[i] = '0;
        end
        s_pc = '0;
        repeat (reset_cycles) begin
            #1;
            check_value("addr_rom", '0, addr_rom);
            check_value("enable_w", '0, enable_w);
            @(negedge CLK);
        end
        RESET_N  = 1'b1;
        checking = 1'b1;
        repeat (cycles) @(negedge CLK);
        checking = 1'b0;
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d mismatches", name, error_count - errors_before);
        end
    endtask

    task automatic build_arith_program();
        int slot;
        slot = 0;
        clear_rom();
        emit(enc_i(opc_op_imm, 3'd0, 5'd1, 5'd0, 12'hff9));  // x1 = -7.
        emit(enc_i(opc_op_imm, 3'd0, 5'd2, 5'd0, 12'd3));
        emit(enc_u(opc_lui, 5'd3, 20'h80000));
        emit(enc_i(opc_op_imm, 3'd0, 5'd3, 5'd3, 12'd5));
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(1'b0, 3'(f), 5'd4, 5'd1, 5'd2));
            store_slot(5'd4, slot);
            slot++;
            emit(enc_r(1'b0, 3'(f), 5'd4, 5'd3, 5'd1));
            store_slot(5'd4, slot);
            slot++;
            if (f == 0 || f == 5) begin  // sub and sra.
                emit(enc_r(1'b1, 3'(f), 5'd4, 5'd1, 5'd2));
                store_slot(5'd4, slot);
                slot++;
            end
            emit(enc_i(opc_op_imm, 3'(f), 5'd5, 5'd1,
                       (f == 1 || f == 5) ? 12'd3 : 12'hff0));
            store_slot(5'd5, slot);
            slot++;
        end
        emit(enc_i(opc_op_imm, 3'd5, 5'd6, 5'd3, 12'h403));  // srai.
        store_slot(5'd6, slot);
    endtask

    task automatic build_random_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          t;
        clear_rom();
        emit(enc_i(opc_op_imm, 3'd0, 5'd1, 5'd0, 12'd512));  // x1 is the ram base.
        for (int k = 1; k <= 200; k++) begin
            rd  = 5'($urandom_range(0, 31));
            rs1 = 5'($urandom_range(0, 31));
            rs2 = 5'($urandom_range(0, 31));
            f3  = 3'($urandom_range(0, 7));
            imm = 12'($urandom);
            if (rd == 5'd1) rd = 5'd2;
            case ($urandom_range(0, 5))
                0: emit(enc_r((f3 == 0 || f3 == 5) ? 1'($urandom_range(0, 1)) : 1'b0,
                              f3, rd, rs1, rs2));
                1: begin
                    if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
                    if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                    emit(enc_i(opc_op_imm, f3, rd, rs1, imm));
                end
                2: emit(enc_i(opc_load, 3'd2, rd, 5'd1, 12'(4 * $urandom_range(0, 127))));
                3: emit(enc_s(rs2, 5'd1, 12'(4 * $urandom_range(0, 127))));
                4: begin
                    t = $urandom_range(1, 200);
                    if (t == k) t = (k == 200) ? 1 : k + 1;
                    emit(enc_b({2'b0, f3[0]}, rs1, rs2, 13'(4 * (t - k))));
                end
                default: emit(enc_u(f3[0] ? opc_lui : opc_auipc, rd, 20'($urandom)));
            endcase
        end
    endtask

    initial begin
        RESET_N     = 1'b0;
        checking    = 1'b0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        void'($urandom(52));
        clear_rom();
        fill_ram();
        @(negedge CLK);

        clear_rom();
        emit(enc_s(5'd0, 5'd0, 12'h100));  // a store first, held off during reset.
        emit(enc_i(opc_op_imm, 3'd0, 5'd1, 5'd0, 12'd9));
        emit(enc_s(5'd1, 5'd0, 12'h104));
        run_test("reset", test_cycles);

        build_arith_program();
        run_test("arithmetic", test_cycles);

        clear_rom();
        emit(enc_i(opc_op_imm, 3'd0, 5'd5, 5'd0, 12'h123));
        emit(enc_s(5'd5, 5'd0, 12'h300));
        emit(enc_i(opc_load, 3'd2, 5'd6, 5'd0, 12'h300));
        emit(enc_s(5'd6, 5'd0, 12'h304));
        emit(enc_i(opc_op_imm, 3'd0, 5'd0, 5'd0, 12'd55));  // write to x0.
        emit(enc_s(5'd0, 5'd0, 12'h308));
        emit(enc_i(opc_load, 3'd2, 5'd7, 5'd0, 12'h010));
        emit(enc_s(5'd7, 5'd0, 12'h30c));
        emit(enc_i(opc_load, 3'd2, 5'd0, 5'd0, 12'h014));
        emit(enc_s(5'd0, 5'd0, 12'h310));
        run_test("load_store", test_cycles);

        clear_rom();
        emit(enc_i(opc_op_imm, 3'd0, 5'd1, 5'd0, 12'd5));
        emit(enc_i(opc_op_imm, 3'd0, 5'd2, 5'd0, 12'd5));
        emit(enc_i(opc_op_imm, 3'd0, 5'd3, 5'd0, 12'd3));
        emit(enc_b(3'd0, 5'd1, 5'd2, 13'd8));   // beq taken, forward.
        emit(enc_s(5'd3, 5'd0, 12'h200));
        emit(enc_b(3'd1, 5'd1, 5'd2, 13'd8));   // bne not taken.
        emit(enc_i(opc_op_imm, 3'd0, 5'd4, 5'd4, 12'd1));
        emit(enc_b(3'd1, 5'd4, 5'd3, -13'sd4));  // bne taken backward until x4 is 3.
        emit(enc_b(3'd0, 5'd4, 5'd1, 13'd8));   // beq not taken.
        emit(enc_s(5'd4, 5'd0, 12'h204));
        emit(enc_b(3'd0, 5'd0, 5'd0, 13'd0));   // spin here.
        run_test("branches", test_cycles);

        clear_rom();
        emit(enc_u(opc_lui, 5'd1, 20'habcde));
        emit(enc_s(5'd1, 5'd0, 12'h200));
        emit(enc_u(opc_auipc, 5'd2, 20'h12345));
        emit(enc_s(5'd2, 5'd0, 12'h204));
        emit(enc_u(opc_lui, 5'd3, 20'hfffff));
        emit(enc_i(opc_op_imm, 3'd0, 5'd3, 5'd3, 12'hfff));
        emit(enc_s(5'd3, 5'd0, 12'h208));
        emit(enc_u(opc_auipc, 5'd4, 20'h0));
        emit(enc_s(5'd4, 5'd0, 12'h20c));
        run_test("upper_immediate", test_cycles);

        build_random_program();
        run_test("random", rand_cycles);

        if (i_rv_core.i_rv_core_assertions.failures != 0) begin
            $display("%0d assertion failures were seen",
                     i_rv_core.i_rv_core_assertions.failures);
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && i_rv_core.i_rv_core_assertions.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(total_cycles * 10 + 1000);
        $display("the run timed out before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

/* build.f */
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_core.sv
test/rv_core_assertions.sv
test/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - logic/rv_pkg.sv
      - logic/rv_decoder.sv
      - logic/rv_regfile.sv
      - logic/rv_alu.sv
      - logic/rv_core.sv
  - target: test
    files:
      - test/rv_core_assertions.sv
      - test/rv_core_tb.sv
